/* Bender.yml */
package:
  name: retire_stage

sources:
  - hw/retire_pkg.sv
  - hw/retire_int_sel.sv
  - hw/retire_expt_prio.sv
  - hw/retire_mbkpt_fsm.sv
  - hw/retire_dbg_ctrl.sv
  - hw/retire_top.sv
  - target: simulation
    files:
      - tb/retire_tb.sv

/* compile.f */
hw/retire_pkg.sv
hw/retire_int_sel.sv
hw/retire_expt_prio.sv
hw/retire_mbkpt_fsm.sv
hw/retire_dbg_ctrl.sv
hw/retire_top.sv
tb/retire_tb.sv

/* hw/retire_dbg_ctrl.sv */
/*
 * debug request acknowledge, debug mode flag, exception / interrupt
 * commit, pipeline flush and normal retire
 */
`timescale 1ns/100ps

module retire_dbg_ctrl
(
  input  logic                  dbg_clk,
  input  logic                  cpurst_b,
  input  logic                  rbus_retire_cmplt,
  input  logic                  rbus_retire_expt_vld,
  input  retire_pkg::rbus_vec_t rbus_retire_expt_vec,
  input  logic                  rbus_retire_flush,
  input  logic                  ack_int,
  input  logic                  ack_expt,
  input  logic                  mbkpt_dbg_ack,
  input  logic                  mbkpt_expt,
  input  logic                  had_iu_mem_bkpt_req,
  input  logic                  had_iu_xx_jdbreq,
  input  logic                  had_iu_xx_fdb,
  input  logic                  had_iu_dr_set_req,
  input  logic                  had_iu_force_dbg_en,
  input  logic                  had_yy_xx_exit_dbg,
  input  logic                  ex_inst_dbg_disable,
  output logic                  iu_yy_xx_retire,
  output logic                  iu_cp0_expt_vld,
  output logic                  iu_cp0_int_vld,
  output logic                  iu_yy_xx_flush,
  output logic                  iu_yy_xx_dbgon,
  output logic                  iu_had_xx_dbg_ack,
  output logic                  iu_had_xx_bkpt_inst,
  output logic                  retire_xx_normal_retire
);

  import retire_pkg::*;

  logic dbg_ack;
  logic dbg_mode_on;
  logic ack_jdbreq;
  logic ack_bkpt;
  logic ack_dr_set;
  logic dbg_ack_any;
  logic expt_commit;
  logic int_commit;

  assign iu_yy_xx_retire = rbus_retire_cmplt;

  assign ack_jdbreq = had_iu_xx_jdbreq && !ex_inst_dbg_disable;

  // ebreak enters debug only with fdb
  assign ack_bkpt = rbus_retire_cmplt && rbus_retire_expt_vld
                 && (rbus_retire_expt_vec == RBUS_VEC_BKPT)
                 && had_iu_xx_fdb && !dbg_mode_on && !ex_inst_dbg_disable;

  assign ack_dr_set = rbus_retire_cmplt && had_iu_dr_set_req && !ex_inst_dbg_disable;

  assign dbg_ack_any = ack_jdbreq || ack_bkpt || ack_dr_set
                    || mbkpt_dbg_ack || had_iu_force_dbg_en;

  // debug entry takes precedence over any trap
  assign expt_commit = ((rbus_retire_cmplt && ack_expt) || mbkpt_expt)
                    && !dbg_mode_on && !dbg_ack_any;

  assign int_commit = rbus_retire_cmplt && ack_int && !had_iu_mem_bkpt_req
                   && !dbg_mode_on && !dbg_ack_any;

  assign iu_cp0_expt_vld = expt_commit;
  assign iu_cp0_int_vld  = int_commit;

  assign iu_yy_xx_flush = (rbus_retire_cmplt && rbus_retire_flush)
                       || expt_commit || int_commit || dbg_ack_any;

  assign retire_xx_normal_retire = rbus_retire_cmplt
                                && !(rbus_retire_expt_vld && !dbg_mode_on);

  assign iu_had_xx_bkpt_inst = ack_bkpt;

  always_ff @(posedge dbg_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dbg_ack <= 1'b0;
    end
    else
    begin
      dbg_ack <= dbg_ack_any;
    end
  end

  // exit beats a new acknowledge in the same cycle
  always_ff @(posedge dbg_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dbg_mode_on <= 1'b0;
    end
    else if (had_yy_xx_exit_dbg)
    begin
      dbg_mode_on <= 1'b0;
    end
    else if (dbg_ack_any)
    begin
      dbg_mode_on <= 1'b1;
    end
  end

  assign iu_had_xx_dbg_ack = dbg_ack;
  assign iu_yy_xx_dbgon    = dbg_mode_on;

endmodule

/* hw/retire_expt_prio.sv */
/*
 * interrupt versus instruction exception priority and vector encoding
 */
`timescale 1ns/100ps

module retire_expt_prio
(
  input  logic                  int_vld,
  input  logic                  decd_retire_inst_mret,
  input  logic                  ctrl_retire_ni_vld,
  input  logic                  rbus_retire_expt_vld,
  input  retire_pkg::rbus_vec_t rbus_retire_expt_vec,
  input  retire_pkg::vec_mode_t cp0_iu_vec_mode,
  input  retire_pkg::int_id_t   clic_cpu_int_id,
  output logic                  ack_int,
  output logic                  ack_expt,
  output retire_pkg::expt_vec_t expt_vec
);

  import retire_pkg::*;

  logic take_int;

  // mret and no-interrupt instructions hold the interrupt off
  assign take_int = int_vld && !decd_retire_inst_mret && !ctrl_retire_ni_vld;

  always_comb
  begin
    ack_int  = 1'b0;
    ack_expt = 1'b0;
    expt_vec = '0;
    if (take_int)
    begin
      ack_int = 1'b1;
      if (cp0_iu_vec_mode[1])
      begin
        expt_vec = clic_cpu_int_id;
      end
      else
      begin
        expt_vec = VEC_CLINT_EXT;
      end
    end
    else if (rbus_retire_expt_vld)
    begin
      ack_expt = 1'b1;
      expt_vec = {5'b0, rbus_retire_expt_vec};
    end
  end

endmodule

/* hw/retire_int_sel.sv */
/*
 * external interrupt sampling and clint / clic interrupt qualification
 */
`timescale 1ns/100ps

module retire_int_sel
(
  input  logic                   dbg_clk,
  input  logic                   cpurst_b,
  input  logic                   pad_cpu_ext_int_b,
  input  logic                   cp0_iu_meie,
  input  logic                   cp0_iu_mie_for_int,
  input  retire_pkg::vec_mode_t  cp0_iu_vec_mode,
  input  retire_pkg::int_level_t cp0_iu_il,
  input  retire_pkg::int_level_t clic_cpu_int_il,
  output logic                   int_vld,
  output logic                   nt_int_pending
);

  logic cpu_ext_int_b;
  logic clint_int_vld;
  logic clic_int_pending;
  logic clic_int_vld;

  // pad line is active low, idle high out of reset
  always_ff @(posedge dbg_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cpu_ext_int_b <= 1'b1;
    end
    else
    begin
      cpu_ext_int_b <= pad_cpu_ext_int_b;
    end
  end

  assign nt_int_pending = !cpu_ext_int_b;

  assign clint_int_vld = !cpu_ext_int_b && cp0_iu_meie && cp0_iu_mie_for_int;

  // level zero means nothing pending
  assign clic_int_pending = |clic_cpu_int_il;
  assign clic_int_vld     = clic_int_pending
                         && (clic_cpu_int_il > cp0_iu_il)
                         && cp0_iu_mie_for_int;

  assign int_vld = cp0_iu_vec_mode[1] ? clic_int_vld : clint_int_vld;

endmodule

/* hw/retire_mbkpt_fsm.sv */
/*
 * memory breakpoint fsm, holds a load/store hit until writeback completes
 */
`timescale 1ns/100ps

module retire_mbkpt_fsm
(
  input  logic dbg_clk,
  input  logic cpurst_b,
  input  logic had_iu_mem_bkpt_req,
  input  logic had_iu_mbkpt_fsm_index_mbee,
  input  logic ex_inst_dbg_disable,
  input  logic rbus_wb_load,
  input  logic rbus_wb_store,
  input  logic lsu_iu_wb_cmplt,
  input  logic lsu_iu_wb_acc_err,
  output logic mbkpt_dbg_ack,
  output logic mbkpt_expt,
  output logic dbg_in_ack
);

  import retire_pkg::*;

  mbkpt_state_e cur_state;
  mbkpt_state_e next_state;
  logic         ldst;
  logic         trigger;
  logic         wb_done;

  assign ldst    = rbus_wb_load || rbus_wb_store;
  assign trigger = had_iu_mem_bkpt_req && ldst && !ex_inst_dbg_disable;

  always_ff @(posedge dbg_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cur_state <= MBKPT_IDLE;
    end
    else
    begin
      cur_state <= next_state;
    end
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      MBKPT_IDLE:
      begin
        if (trigger)
        begin
          next_state = MBKPT_ACK;
        end
      end
      MBKPT_ACK:
      begin
        if (lsu_iu_wb_cmplt)
        begin
          next_state = MBKPT_IDLE;
        end
      end
      default:
      begin
        next_state = MBKPT_IDLE;
      end
    endcase
  end

  // good completion of the pending access
  assign wb_done = (cur_state == MBKPT_ACK) && lsu_iu_wb_cmplt && !lsu_iu_wb_acc_err;

  // non load/store hits are taken at once
  assign mbkpt_dbg_ack = ((cur_state == MBKPT_IDLE) && had_iu_mem_bkpt_req
                          && !ldst && !ex_inst_dbg_disable)
                      || (wb_done && !had_iu_mbkpt_fsm_index_mbee);

  assign mbkpt_expt = wb_done && had_iu_mbkpt_fsm_index_mbee;
  assign dbg_in_ack = (cur_state == MBKPT_ACK);

endmodule

/* hw/retire_pkg.sv */
/*
 * retire stage shared types: pc, vector and interrupt widths,
 * fixed vector codes and the memory breakpoint state encoding
 */
package retire_pkg;

  // pc without bit 0, instructions are halfword aligned
  typedef logic [30:0] pc_t;
  typedef logic [31:0] pad_pc_t;

  typedef logic [9:0] expt_vec_t;
  typedef logic [4:0] rbus_vec_t;

  typedef logic [7:0] int_level_t;
  typedef logic [9:0] int_id_t;

  // bit 1 selects clic
  typedef logic [1:0] vec_mode_t;

  // machine external interrupt
  localparam expt_vec_t VEC_CLINT_EXT = 10'd11;

  // ebreak
  localparam rbus_vec_t RBUS_VEC_BKPT = 5'd3;

  typedef enum logic
  {
    MBKPT_IDLE = 1'b0,
    MBKPT_ACK  = 1'b1
  } mbkpt_state_e;

endpackage

/* hw/retire_top.sv */
/*
 * retire stage top: interrupt select, trap priority, memory breakpoint
 * fsm and debug control, plus the retire pc to the pad
 */
`timescale 1ns/100ps

module retire_top
(
  input  logic                   dbg_clk,
  input  logic                   cpurst_b,
  input  logic                   pad_cpu_ext_int_b,
  input  logic                   cp0_iu_meie,
  input  logic                   cp0_iu_mie_for_int,
  input  retire_pkg::vec_mode_t  cp0_iu_vec_mode,
  input  retire_pkg::int_level_t cp0_iu_il,
  input  retire_pkg::int_level_t clic_cpu_int_il,
  input  retire_pkg::int_id_t    clic_cpu_int_id,
  input  logic                   decd_retire_inst_mret,
  input  logic                   ctrl_retire_ni_vld,
  input  logic                   rbus_retire_cmplt,
  input  logic                   rbus_retire_expt_vld,
  input  retire_pkg::rbus_vec_t  rbus_retire_expt_vec,
  input  logic                   rbus_retire_flush,
  input  logic                   rbus_wb_load,
  input  logic                   rbus_wb_store,
  input  logic                   lsu_iu_wb_cmplt,
  input  logic                   lsu_iu_wb_acc_err,
  input  logic                   had_iu_mem_bkpt_req,
  input  logic                   had_iu_mbkpt_fsm_index_mbee,
  input  logic                   had_iu_xx_jdbreq,
  input  logic                   had_iu_xx_fdb,
  input  logic                   had_iu_dr_set_req,
  input  logic                   had_iu_force_dbg_en,
  input  logic                   had_yy_xx_exit_dbg,
  input  logic                   ex_inst_dbg_disable,
  input  retire_pkg::pc_t        pcgen_xx_cur_pc,
  output logic                   iu_yy_xx_retire,
  output logic                   iu_cp0_expt_vld,
  output logic                   iu_cp0_int_vld,
  output logic                   iu_yy_xx_flush,
  output logic                   iu_yy_xx_dbgon,
  output logic                   iu_had_xx_dbg_ack,
  output logic                   iu_had_xx_bkpt_inst,
  output logic                   retire_xx_normal_retire,
  output retire_pkg::expt_vec_t  iu_yy_xx_expt_vec,
  output logic                   iu_had_data_bkpt_occur_vld,
  output logic                   retire_wb_dbg_in_ack,
  output logic                   iu_cp0_nt_int_pending_vld,
  output retire_pkg::pad_pc_t    iu_pad_retire_pc
);

  logic int_vld;
  logic ack_int;
  logic ack_expt;
  logic mbkpt_dbg_ack;
  logic mbkpt_expt;

  retire_int_sel retire_int_sel_i
  (
    .dbg_clk            (dbg_clk),
    .cpurst_b           (cpurst_b),
    .pad_cpu_ext_int_b  (pad_cpu_ext_int_b),
    .cp0_iu_meie        (cp0_iu_meie),
    .cp0_iu_mie_for_int (cp0_iu_mie_for_int),
    .cp0_iu_vec_mode    (cp0_iu_vec_mode),
    .cp0_iu_il          (cp0_iu_il),
    .clic_cpu_int_il    (clic_cpu_int_il),
    .int_vld            (int_vld),
    .nt_int_pending     (iu_cp0_nt_int_pending_vld)
  );

  retire_expt_prio retire_expt_prio_i
  (
    .int_vld               (int_vld),
    .decd_retire_inst_mret (decd_retire_inst_mret),
    .ctrl_retire_ni_vld    (ctrl_retire_ni_vld),
    .rbus_retire_expt_vld  (rbus_retire_expt_vld),
    .rbus_retire_expt_vec  (rbus_retire_expt_vec),
    .cp0_iu_vec_mode       (cp0_iu_vec_mode),
    .clic_cpu_int_id       (clic_cpu_int_id),
    .ack_int               (ack_int),
    .ack_expt              (ack_expt),
    .expt_vec              (iu_yy_xx_expt_vec)
  );

  retire_mbkpt_fsm retire_mbkpt_fsm_i
  (
    .dbg_clk                     (dbg_clk),
    .cpurst_b                    (cpurst_b),
    .had_iu_mem_bkpt_req         (had_iu_mem_bkpt_req),
    .had_iu_mbkpt_fsm_index_mbee (had_iu_mbkpt_fsm_index_mbee),
    .ex_inst_dbg_disable         (ex_inst_dbg_disable),
    .rbus_wb_load                (rbus_wb_load),
    .rbus_wb_store               (rbus_wb_store),
    .lsu_iu_wb_cmplt             (lsu_iu_wb_cmplt),
    .lsu_iu_wb_acc_err           (lsu_iu_wb_acc_err),
    .mbkpt_dbg_ack               (mbkpt_dbg_ack),
    .mbkpt_expt                  (mbkpt_expt),
    .dbg_in_ack                  (retire_wb_dbg_in_ack)
  );

  retire_dbg_ctrl retire_dbg_ctrl_i
  (
    .dbg_clk                 (dbg_clk),
    .cpurst_b                (cpurst_b),
    .rbus_retire_cmplt       (rbus_retire_cmplt),
    .rbus_retire_expt_vld    (rbus_retire_expt_vld),
    .rbus_retire_expt_vec    (rbus_retire_expt_vec),
    .rbus_retire_flush       (rbus_retire_flush),
    .ack_int                 (ack_int),
    .ack_expt                (ack_expt),
    .mbkpt_dbg_ack           (mbkpt_dbg_ack),
    .mbkpt_expt              (mbkpt_expt),
    .had_iu_mem_bkpt_req     (had_iu_mem_bkpt_req),
    .had_iu_xx_jdbreq        (had_iu_xx_jdbreq),
    .had_iu_xx_fdb           (had_iu_xx_fdb),
    .had_iu_dr_set_req       (had_iu_dr_set_req),
    .had_iu_force_dbg_en     (had_iu_force_dbg_en),
    .had_yy_xx_exit_dbg      (had_yy_xx_exit_dbg),
    .ex_inst_dbg_disable     (ex_inst_dbg_disable),
    .iu_yy_xx_retire         (iu_yy_xx_retire),
    .iu_cp0_expt_vld         (iu_cp0_expt_vld),
    .iu_cp0_int_vld          (iu_cp0_int_vld),
    .iu_yy_xx_flush          (iu_yy_xx_flush),
    .iu_yy_xx_dbgon          (iu_yy_xx_dbgon),
    .iu_had_xx_dbg_ack       (iu_had_xx_dbg_ack),
    .iu_had_xx_bkpt_inst     (iu_had_xx_bkpt_inst),
    .retire_xx_normal_retire (retire_xx_normal_retire)
  );

  assign iu_had_data_bkpt_occur_vld = mbkpt_dbg_ack;

  // restore byte address
  assign iu_pad_retire_pc = {pcgen_xx_cur_pc, 1'b0};

endmodule

/* tb/retire_tb.sv */
/*
 * retire stage testbench with a row table of stimulus and expected outputs
 * clock and reset, compare task and cycle limit
 */
`timescale 1ns/100ps

module retire_tb;

  import retire_pkg::*;

  localparam int NROWS      = 22;
  localparam int RST_CYCLES = 8;
  localparam int MAX_CYCLES = NROWS + RST_CYCLES + 20;

  logic       dbg_clk;
  logic       cpurst_b;
  logic       pad_cpu_ext_int_b;
  logic       cp0_iu_meie;
  logic       cp0_iu_mie_for_int;
  vec_mode_t  cp0_iu_vec_mode;
  int_level_t cp0_iu_il;
  int_level_t clic_cpu_int_il;
  int_id_t    clic_cpu_int_id;
  logic       decd_retire_inst_mret;
  logic       ctrl_retire_ni_vld;
  logic       rbus_retire_cmplt;
  logic       rbus_retire_expt_vld;
  logic       rbus_retire_flush;
  rbus_vec_t  rbus_retire_expt_vec;
  logic       rbus_wb_load;
  logic       rbus_wb_store;
  logic       lsu_iu_wb_cmplt;
  logic       lsu_iu_wb_acc_err;
  logic       had_iu_mem_bkpt_req;
  logic       had_iu_mbkpt_fsm_index_mbee;
  logic       had_iu_xx_jdbreq;
  logic       had_iu_xx_fdb;
  logic       had_iu_dr_set_req;
  logic       had_iu_force_dbg_en;
  logic       had_yy_xx_exit_dbg;
  logic       ex_inst_dbg_disable;
  pc_t        pcgen_xx_cur_pc;
  logic       iu_yy_xx_retire;
  logic       iu_cp0_expt_vld;
  logic       iu_cp0_int_vld;
  logic       iu_yy_xx_flush;
  logic       iu_yy_xx_dbgon;
  logic       iu_had_xx_dbg_ack;
  logic       iu_had_xx_bkpt_inst;
  logic       retire_xx_normal_retire;
  logic       iu_had_data_bkpt_occur_vld;
  logic       retire_wb_dbg_in_ack;
  logic       iu_cp0_nt_int_pending_vld;
  expt_vec_t  iu_yy_xx_expt_vec;
  pad_pc_t    iu_pad_retire_pc;

  // stimulus columns pad_b meie mie clic mret cmplt expt flush load wb_cmplt
  // mbee bkpt_req fdb exit rbus_code clic_level
  logic [26:0] stim_tab [NROWS];
  // expected columns retire int expt flush normal dbgon dbg_ack bkpt_inst
  // data_bkpt in_ack nt_pend vector
  logic [20:0] exp_tab [NROWS];
  logic [31:0] pc_state;
  int          cycle_cnt = 0;
  int          i;

  retire_top retire_top_i (.*);

  initial
  begin
    dbg_clk = 1'b0;
    forever
    begin
      #20 dbg_clk = !dbg_clk;
    end
  end

  always @(posedge dbg_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic fill_table;
    // clint interrupt then retire with and without mret
    stim_tab[0]  = {14'b0110_0000_0000_00, 5'd0, 8'd0};
    exp_tab[0]   = {11'b0000_0000_000, 10'd0};
    stim_tab[1]  = {14'b0110_0000_0000_00, 5'd0, 8'd0};
    exp_tab[1]   = {11'b0000_0000_001, 10'd11};
    stim_tab[2]  = {14'b0110_0100_0000_00, 5'd0, 8'd0};
    exp_tab[2]   = {11'b1101_1000_001, 10'd11};
    stim_tab[3]  = {14'b0110_1100_0000_00, 5'd0, 8'd0};
    exp_tab[3]   = {11'b1000_1000_001, 10'd0};
    stim_tab[4]  = {14'b1110_0000_0000_00, 5'd0, 8'd0};
    exp_tab[4]   = {11'b0000_0000_001, 10'd11};
    // clic levels against threshold 4
    stim_tab[5]  = {14'b1011_0100_0000_00, 5'd0, 8'd5};
    exp_tab[5]   = {11'b1101_1000_000, 10'h2a5};
    stim_tab[6]  = {14'b1011_0100_0000_00, 5'd0, 8'd4};
    exp_tab[6]   = {11'b1000_1000_000, 10'd0};
    stim_tab[7]  = {14'b1011_0100_0000_00, 5'd0, 8'd0};
    exp_tab[7]   = {11'b1000_1000_000, 10'd0};
    // instruction exception
    stim_tab[8]  = {14'b1000_0110_0000_00, 5'd2, 8'd0};
    exp_tab[8]   = {11'b1011_0000_000, 10'd2};
    // ebreak with fdb then debug mode and exit
    stim_tab[9]  = {14'b1000_0110_0000_10, 5'd3, 8'd0};
    exp_tab[9]   = {11'b1001_0001_000, 10'd3};
    stim_tab[10] = {14'b1000_0110_0000_00, 5'd2, 8'd0};
    exp_tab[10]  = {11'b1000_1110_000, 10'd2};
    stim_tab[11] = {14'b1000_0000_0000_01, 5'd0, 8'd0};
    exp_tab[11]  = {11'b0000_0100_000, 10'd0};
    stim_tab[12] = {14'b1000_0000_0000_00, 5'd0, 8'd0};
    exp_tab[12]  = {11'b0000_0000_000, 10'd0};
    // memory breakpoint on a load with mbee clear
    stim_tab[13] = {14'b1000_0000_1001_00, 5'd0, 8'd0};
    exp_tab[13]  = {11'b0000_0000_000, 10'd0};
    stim_tab[14] = {14'b1000_0000_0001_00, 5'd0, 8'd0};
    exp_tab[14]  = {11'b0000_0000_010, 10'd0};
    stim_tab[15] = {14'b1000_0000_0101_00, 5'd0, 8'd0};
    exp_tab[15]  = {11'b0001_0000_110, 10'd0};
    stim_tab[16] = {14'b1000_0000_0000_00, 5'd0, 8'd0};
    exp_tab[16]  = {11'b0000_0110_000, 10'd0};
    stim_tab[17] = {14'b1000_0000_0000_01, 5'd0, 8'd0};
    exp_tab[17]  = {11'b0000_0100_000, 10'd0};
    // same with mbee set so it becomes an exception
    stim_tab[18] = {14'b1000_0000_1011_00, 5'd0, 8'd0};
    exp_tab[18]  = {11'b0000_0000_000, 10'd0};
    stim_tab[19] = {14'b1000_0000_0011_00, 5'd0, 8'd0};
    exp_tab[19]  = {11'b0000_0000_010, 10'd0};
    stim_tab[20] = {14'b1000_0000_0111_00, 5'd0, 8'd0};
    exp_tab[20]  = {11'b0011_0000_010, 10'd0};
    stim_tab[21] = {14'b1000_0000_0000_00, 5'd0, 8'd0};
    exp_tab[21]  = {11'b0000_0000_000, 10'd0};
  endtask

  task automatic apply_row(input logic [26:0] s, input logic [31:0] rnd);
    pad_cpu_ext_int_b           <= s[26];
    cp0_iu_meie                 <= s[25];
    cp0_iu_mie_for_int          <= s[24];
    cp0_iu_vec_mode             <= {s[23], 1'b1};
    decd_retire_inst_mret       <= s[22];
    rbus_retire_cmplt           <= s[21];
    rbus_retire_expt_vld        <= s[20];
    rbus_retire_flush           <= s[19];
    rbus_wb_load                <= s[18];
    lsu_iu_wb_cmplt             <= s[17];
    had_iu_mbkpt_fsm_index_mbee <= s[16];
    had_iu_mem_bkpt_req         <= s[15];
    had_iu_xx_fdb               <= s[14];
    had_yy_xx_exit_dbg          <= s[13];
    rbus_retire_expt_vec        <= s[12:8];
    clic_cpu_int_il             <= s[7:0];
    pcgen_xx_cur_pc             <= rnd[30:0];
  endtask

  task automatic check_row(input logic [20:0] e);
    compare_value("iu_yy_xx_retire", iu_yy_xx_retire, e[20]);
    compare_value("iu_cp0_int_vld", iu_cp0_int_vld, e[19]);
    compare_value("iu_cp0_expt_vld", iu_cp0_expt_vld, e[18]);
    compare_value("iu_yy_xx_flush", iu_yy_xx_flush, e[17]);
    compare_value("retire_xx_normal_retire", retire_xx_normal_retire, e[16]);
    compare_value("iu_yy_xx_dbgon", iu_yy_xx_dbgon, e[15]);
    compare_value("iu_had_xx_dbg_ack", iu_had_xx_dbg_ack, e[14]);
    compare_value("iu_had_xx_bkpt_inst", iu_had_xx_bkpt_inst, e[13]);
    compare_value("iu_had_data_bkpt_occur_vld", iu_had_data_bkpt_occur_vld, e[12]);
    compare_value("retire_wb_dbg_in_ack", retire_wb_dbg_in_ack, e[11]);
    compare_value("iu_cp0_nt_int_pending_vld", iu_cp0_nt_int_pending_vld, e[10]);
    compare_value("iu_yy_xx_expt_vec", iu_yy_xx_expt_vec, e[9:0]);
    // byte pc is the halfword pc shifted up one bit
    compare_value("iu_pad_retire_pc", iu_pad_retire_pc, {1'b0, pcgen_xx_cur_pc} << 1);
  endtask

  initial
  begin
    cpurst_b = 1'b0;
    apply_row({14'b1000_0000_0000_00, 5'd0, 8'd0}, 32'd0);
    cp0_iu_il           = 8'd4;
    clic_cpu_int_id     = 10'h2a5;
    ctrl_retire_ni_vld  = 1'b0;
    rbus_wb_store       = 1'b0;
    lsu_iu_wb_acc_err   = 1'b0;
    had_iu_xx_jdbreq    = 1'b0;
    had_iu_dr_set_req   = 1'b0;
    had_iu_force_dbg_en = 1'b0;
    ex_inst_dbg_disable = 1'b0;
    pc_state = 32'd39;
    fill_table();
    repeat (RST_CYCLES) @(posedge dbg_clk);
    cpurst_b <= 1'b1;
    for (i = 0; i < NROWS; i++)
    begin
      @(posedge dbg_clk);
      pc_state = xorshift32(pc_state);
      apply_row(stim_tab[i], pc_state);
      @(negedge dbg_clk);
      check_row(exp_tab[i]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
